// File: Bender.yml
package:
  name: counter_apb

sources:
  - src/counter_pkg.sv
  - src/counter_apb_regs.sv
  - src/counter_channel.sv
  - src/counter_intr_ctrl.sv
  - src/counter_top.sv
  - target: test
    files:
      - tests/tb_counter_top.sv

// File: flist.f
src/counter_pkg.sv
src/counter_apb_regs.sv
src/counter_channel.sv
src/counter_intr_ctrl.sv
src/counter_top.sv
tests/tb_counter_top.sv

// File: src/counter_apb_regs.sv
`timescale 1ns/100ps

module counter_apb_regs #(
  parameter int COUNTER_NUM = 4
) (
  input  logic                                     i_pclk,
  input  logic                                     i_prst_n,
  input  logic [counter_pkg::APB_AW-1:0]           i_paddr,
  input  logic [counter_pkg::DATA_W-1:0]           i_pwdata,
  input  logic                                     i_pwrite,
  input  logic                                     i_psel,
  input  logic                                     i_penable,
  input  counter_pkg::chan_sts_t [COUNTER_NUM-1:0] i_sts,
  input  logic [counter_pkg::DATA_W-1:0]           i_intr_status,
  input  logic [counter_pkg::DATA_W-1:0]           i_intr_mask,
  output logic [counter_pkg::DATA_W-1:0]           o_prdata,
  output counter_pkg::chan_cfg_t [COUNTER_NUM-1:0] o_cfg,
  output logic [COUNTER_NUM-1:0]                   o_clear,
  output logic                                     o_intr_clr_wr,
  output logic                                     o_intr_set_wr,
  output logic                                     o_mask_set_wr,
  output logic                                     o_mask_clr_wr,
  output logic [counter_pkg::DATA_W-1:0]           o_intr_wdata
);
  import counter_pkg::*;

  // low address bits that select a register inside a channel block
  localparam int STRIDE_LSB = $clog2(CHAN_STRIDE);

  logic                   setup_rd;
  logic                   access_wr;
  logic                   chan_hit;
  logic [APB_AW-1:0]      chan_rel;
  logic [APB_AW-1:0]      chan_idx;
  logic [APB_AW-1:0]      chan_off;
  logic [COUNTER_NUM-1:0] chan_sel;
  logic [DATA_W-1:0]      rdata_nxt;

  // read data is sampled at the end of setup, writes land at the end of access
  assign setup_rd  = i_psel & ~i_penable & ~i_pwrite;
  assign access_wr = i_psel & i_penable & i_pwrite;

  // split channel space into block index and register offset
  assign chan_hit = (i_paddr >= CHAN_BASE);
  assign chan_rel = i_paddr - CHAN_BASE;
  assign chan_idx = chan_rel >> STRIDE_LSB;
  assign chan_off = chan_rel & (CHAN_STRIDE - 1'b1);

  // one select per channel
  // indices past COUNTER_NUM hit nothing and read as zero
  always_comb begin
    for (int n = 0; n < COUNTER_NUM; n++) begin
      chan_sel[n] = chan_hit && (chan_idx == n);
    end
  end

  // clear command is a single cycle strobe on the write edge
  always_comb begin
    for (int n = 0; n < COUNTER_NUM; n++) begin
      o_clear[n] = access_wr && chan_sel[n] && (chan_off == REG_CH_CMD) && i_pwdata[0];
    end
  end

  // interrupt controller strobes, data goes straight through
  assign o_intr_wdata  = i_pwdata;
  assign o_intr_clr_wr = access_wr && (i_paddr == REG_INTR_STATUS);
  assign o_intr_set_wr = access_wr && (i_paddr == REG_INTR_SET);
  assign o_mask_set_wr = access_wr && (i_paddr == REG_MASK_SET);
  assign o_mask_clr_wr = access_wr && (i_paddr == REG_MASK_CLR);

  // ctrl and target registers per channel
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_cfg <= '0;
    end else if (access_wr) begin
      for (int n = 0; n < COUNTER_NUM; n++) begin
        if (chan_sel[n] && (chan_off == REG_CH_CTRL)) begin
          o_cfg[n].enable     <= i_pwdata[0];
          o_cfg[n].capture_en <= i_pwdata[1];
        end
        if (chan_sel[n] && (chan_off == REG_CH_TARGET)) begin
          o_cfg[n].target <= i_pwdata;
        end
      end
    end
  end

  // read-back mux
  // write only and unmapped locations return zero
  always_comb begin
    case (i_paddr)
      REG_INTR_STATUS: rdata_nxt = i_intr_status;
      REG_INTR_MASK:   rdata_nxt = i_intr_mask;
      default:         rdata_nxt = '0;
    endcase
    for (int n = 0; n < COUNTER_NUM; n++) begin
      if (chan_sel[n]) begin
        case (chan_off)
          REG_CH_CTRL: begin
            rdata_nxt = {{(DATA_W-2){1'b0}}, o_cfg[n].capture_en, o_cfg[n].enable};
          end
          REG_CH_TARGET:  rdata_nxt = o_cfg[n].target;
          REG_CH_CAPTURE: rdata_nxt = i_sts[n].capture;
          REG_CH_COUNT:   rdata_nxt = i_sts[n].count;
          default:        rdata_nxt = '0;
        endcase
      end
    end
  end

  // registered so prdata is steady for the whole access phase
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_prdata <= '0;
    end else if (setup_rd) begin
      o_prdata <= rdata_nxt;
    end
  end

  // master must hold address and direction into the access phase
  a_apb_stable: assert property (@(posedge i_pclk) disable iff (!i_prst_n)
    (i_psel && !i_penable) |=> ($stable(i_paddr) && $stable(i_pwrite)));

  // penable only inside a selected transfer
  a_apb_enable: assert property (@(posedge i_pclk) disable iff (!i_prst_n)
    i_penable |-> i_psel);

endmodule

// File: src/counter_channel.sv
`timescale 1ns/100ps

module counter_channel (
  input  logic                   i_pclk,
  input  logic                   i_prst_n,
  input  counter_pkg::chan_cfg_t i_cfg,
  input  logic                   i_clear,
  input  logic                   i_din,
  output counter_pkg::chan_sts_t o_sts,
  output logic                   o_wave
);
  import counter_pkg::*;

  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] capture_q;
  logic              cmp_evt_q;
  logic              cap_evt_q;
  logic              match;
  logic              wrap;
  // din_sync[0] is the first stage
  logic [1:0]        din_sync;
  logic              din_prev;
  logic              din_rise;
  logic              capture_hit;

  // target compare on the live count
  assign match = (count_q == i_cfg.target);

  // clear beats a wrap in the same cycle
  assign wrap = i_cfg.enable & match & ~i_clear;

  // free running up counter
  // wraps to zero after target so one period is target+1 cycles
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      count_q <= '0;
    end else if (i_clear) begin
      count_q <= '0;
    end else if (wrap) begin
      count_q <= '0;
    end else if (i_cfg.enable) begin
      count_q <= count_q + 1'b1;
    end
  end

  // compare pulse and waveform toggle on the wrap edge
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      cmp_evt_q <= 1'b0;
      o_wave    <= 1'b0;
    end else begin
      cmp_evt_q <= wrap;
      if (wrap) begin
        o_wave <= ~o_wave;
      end
    end
  end

  // two flop synchronizer plus one delay flop for edge detect
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      din_sync <= '0;
      din_prev <= 1'b0;
    end else begin
      din_sync <= {din_sync[0], i_din};
      din_prev <= din_sync[1];
    end
  end

  // rising edge seen two edges after din goes high
  assign din_rise = din_sync[1] & ~din_prev;

  // only capture while software allows it
  assign capture_hit = din_rise & i_cfg.capture_en;

  // snapshot of the count, third edge after din rises
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      capture_q <= '0;
      cap_evt_q <= 1'b0;
    end else begin
      cap_evt_q <= capture_hit;
      if (capture_hit) begin
        capture_q <= count_q;
      end
    end
  end

  // status back to the register block and interrupt logic
  assign o_sts.count   = count_q;
  assign o_sts.capture = capture_q;
  assign o_sts.cmp_evt = cmp_evt_q;
  assign o_sts.cap_evt = cap_evt_q;

  // no compare pulse while the channel is stopped
  a_cmp_needs_enable: assert property (@(posedge i_pclk) disable iff (!i_prst_n)
    o_sts.cmp_evt |-> i_cfg.enable);

endmodule

// File: src/counter_intr_ctrl.sv
`timescale 1ns/100ps

module counter_intr_ctrl #(
  parameter int COUNTER_NUM = 4
) (
  input  logic                           i_pclk,
  input  logic                           i_prst_n,
  input  logic [2*COUNTER_NUM-1:0]       i_src,
  input  logic                           i_intr_clr_wr,
  input  logic                           i_intr_set_wr,
  input  logic                           i_mask_set_wr,
  input  logic                           i_mask_clr_wr,
  input  logic [counter_pkg::DATA_W-1:0] i_wdata,
  output logic [counter_pkg::DATA_W-1:0] o_status,
  output logic [counter_pkg::DATA_W-1:0] o_mask,
  output logic                           o_int
);
  import counter_pkg::*;

  localparam int SRC_W = 2 * COUNTER_NUM;
  // bits that belong to a real source
  localparam logic [DATA_W-1:0] USED_MASK = DATA_W'({SRC_W{1'b1}});

  logic [DATA_W-1:0] src_word;
  logic [DATA_W-1:0] set_bits;
  logic [DATA_W-1:0] clr_bits;
  logic [DATA_W-1:0] status_nxt;

  // every source must fit one status word
  if (COUNTER_NUM < 1 || COUNTER_NUM > MAX_COUNTERS) begin : g_num_check
    $error("counter_intr_ctrl: COUNTER_NUM out of range");
  end

  assign src_word = DATA_W'(i_src);
  assign set_bits = i_intr_set_wr ? i_wdata : '0;
  assign clr_bits = i_intr_clr_wr ? i_wdata : '0;

  // sticky status, clear applied last so it wins over a new event
  assign status_nxt = (o_status | src_word | set_bits) & ~clr_bits & USED_MASK;

  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_status <= '0;
    end else begin
      o_status <= status_nxt;
    end
  end

  // mask comes up with all used sources enabled
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_mask <= USED_MASK;
    end else if (i_mask_set_wr) begin
      o_mask <= o_mask | (i_wdata & USED_MASK);
    end else if (i_mask_clr_wr) begin
      o_mask <= o_mask & ~i_wdata;
    end
  end

  // level output, one cycle behind the masked status
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_int <= 1'b0;
    end else begin
      o_int <= |(o_status & o_mask);
    end
  end

  // no status bit above the last channel
  a_status_range: assert property (@(posedge i_pclk) disable iff (!i_prst_n)
    (o_status & ~USED_MASK) == '0);

endmodule

// File: src/counter_pkg.sv
package counter_pkg;

  // APB address width
  localparam int APB_AW = 12;
  // data bus and counter width
  localparam int DATA_W = 32;
  // two interrupt sources per channel must fit in one data word
  localparam int MAX_COUNTERS = 16;

  // global registers

  // sticky status, write 1s to clear
  localparam logic [APB_AW-1:0] REG_INTR_STATUS = 12'h000;
  // software set, write 1s to set status bits
  localparam logic [APB_AW-1:0] REG_INTR_SET    = 12'h004;
  // current mask, read only
  localparam logic [APB_AW-1:0] REG_INTR_MASK   = 12'h008;
  // write 1s to enable sources
  localparam logic [APB_AW-1:0] REG_MASK_SET    = 12'h00C;
  // write 1s to disable sources
  localparam logic [APB_AW-1:0] REG_MASK_CLR    = 12'h010;

  // channel blocks start here, one block per channel
  localparam logic [APB_AW-1:0] CHAN_BASE       = 12'h040;
  localparam logic [APB_AW-1:0] CHAN_STRIDE     = 12'h020;

  // offsets inside a channel block

  // bit 0 enable, bit 1 capture enable
  localparam logic [APB_AW-1:0] REG_CH_CTRL     = 12'h000;
  // bit 0 clear, write only
  localparam logic [APB_AW-1:0] REG_CH_CMD      = 12'h004;
  localparam logic [APB_AW-1:0] REG_CH_TARGET   = 12'h008;
  // read only
  localparam logic [APB_AW-1:0] REG_CH_CAPTURE  = 12'h00C;
  // read only, live count
  localparam logic [APB_AW-1:0] REG_CH_COUNT    = 12'h010;

  // per channel configuration from the register block
  typedef struct packed {
    logic              enable;
    logic              capture_en;
    logic [DATA_W-1:0] target;
  } chan_cfg_t;

  // per channel status back to the register block
  typedef struct packed {
    logic [DATA_W-1:0] count;
    logic [DATA_W-1:0] capture;
    // one cycle pulse on target match
    logic              cmp_evt;
    // one cycle pulse on capture
    logic              cap_evt;
  } chan_sts_t;

endpackage

// File: src/counter_top.sv
`timescale 1ns/100ps

module counter_top #(
  parameter int COUNTER_NUM = 4
) (
  input  logic                           i_pclk,
  input  logic                           i_prst_n,
  input  logic [counter_pkg::APB_AW-1:0] i_paddr,
  input  logic [counter_pkg::DATA_W-1:0] i_pwdata,
  input  logic                           i_pwrite,
  input  logic                           i_psel,
  input  logic                           i_penable,
  output logic [counter_pkg::DATA_W-1:0] o_prdata,
  input  logic [COUNTER_NUM-1:0]         i_extern_din,
  output wire  [COUNTER_NUM-1:0]         o_extern_dout,
  output logic                           o_int
);
  import counter_pkg::*;

  chan_cfg_t [COUNTER_NUM-1:0] cfg;
  // driven per channel from the generate loop
  wire chan_sts_t [COUNTER_NUM-1:0] sts;
  wire [2*COUNTER_NUM-1:0] intr_src;
  logic [COUNTER_NUM-1:0] clear;
  logic                   intr_clr_wr;
  logic                   intr_set_wr;
  logic                   mask_set_wr;
  logic                   mask_clr_wr;
  logic [DATA_W-1:0]      intr_wdata;
  logic [DATA_W-1:0]      intr_status;
  logic [DATA_W-1:0]      intr_mask;

  // APB slave and configuration
  counter_apb_regs #(
    .COUNTER_NUM (COUNTER_NUM)
  ) u_regs (
    .i_pclk        (i_pclk),
    .i_prst_n      (i_prst_n),
    .i_paddr       (i_paddr),
    .i_pwdata      (i_pwdata),
    .i_pwrite      (i_pwrite),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_sts         (sts),
    .i_intr_status (intr_status),
    .i_intr_mask   (intr_mask),
    .o_prdata      (o_prdata),
    .o_cfg         (cfg),
    .o_clear       (clear),
    .o_intr_clr_wr (intr_clr_wr),
    .o_intr_set_wr (intr_set_wr),
    .o_mask_set_wr (mask_set_wr),
    .o_mask_clr_wr (mask_clr_wr),
    .o_intr_wdata  (intr_wdata)
  );

  for (genvar n = 0; n < COUNTER_NUM; n++) begin : g_chan
    counter_channel u_chan (
      .i_pclk   (i_pclk),
      .i_prst_n (i_prst_n),
      .i_cfg    (cfg[n]),
      .i_clear  (clear[n]),
      .i_din    (i_extern_din[n]),
      .o_sts    (sts[n]),
      .o_wave   (o_extern_dout[n])
    );
    // compare on the even bit, capture on the odd bit
    assign intr_src[2*n]   = sts[n].cmp_evt;
    assign intr_src[2*n+1] = sts[n].cap_evt;
  end

  // sticky status, mask and level interrupt
  counter_intr_ctrl #(
    .COUNTER_NUM (COUNTER_NUM)
  ) u_intr (
    .i_pclk        (i_pclk),
    .i_prst_n      (i_prst_n),
    .i_src         (intr_src),
    .i_intr_clr_wr (intr_clr_wr),
    .i_intr_set_wr (intr_set_wr),
    .i_mask_set_wr (mask_set_wr),
    .i_mask_clr_wr (mask_clr_wr),
    .i_wdata       (intr_wdata),
    .o_status      (intr_status),
    .o_mask        (intr_mask),
    .o_int         (o_int)
  );

endmodule

// File: tests/counter_testdata.txt
// op (test in high nibble; 1 wr, 2 rd&mask, 3 wait, 4 din, 5 int, 6 save, 7 same), addr, data, exp
// op 00 ends the data
12 008 FFFFFFFF 000000FF
12 044 FFFFFFFF 00000000
12 050 FFFFFFFF 00000000
12 04C FFFFFFFF 00000000
11 0A8 12345678 00000000
12 0A8 FFFFFFFF 12345678
11 0A0 00000002 00000000
12 0A0 FFFFFFFF 00000002
21 048 FFFFFFFF 00000000
21 040 00000001 00000000
23 000 0000000A 00000000
21 040 00000000 00000000
26 050 00000000 00000000
27 050 00000000 00000000
21 044 00000001 00000000
22 050 FFFFFFFF 00000000
31 068 FFFFFFFF 00000000
31 060 00000001 00000000
33 000 00000006 00000000
31 060 00000000 00000000
36 070 00000000 00000000
31 060 00000002 00000000
34 001 00000001 00000000
33 000 00000005 00000000
37 06C 00000000 00000000
32 000 00000008 00000008
41 088 00000007 00000000
41 080 00000001 00000000
43 000 00000014 00000000
41 080 00000000 00000000
42 000 00000010 00000010
45 000 00000000 00000001
42 090 FFFFFFF8 00000000
51 010 FFFFFFFF 00000000
53 000 00000002 00000000
55 000 00000000 00000000
52 000 00000018 00000018
51 000 FFFFFFFF 00000000
52 000 FFFFFFFF 00000000
51 004 00000040 00000000
51 00C 00000040 00000000
55 000 00000002 00000001
00 000 00000000 00000000

// File: tests/tb_counter_top.sv
`timescale 1ns/100ps

module tb_counter_top;
  import counter_pkg::*;

  localparam int COUNTER_NUM = 4;
  localparam int MAX_STEPS   = 64;

  logic                   pclk;
  logic                   prst_n;
  logic [APB_AW-1:0]      paddr;
  logic [DATA_W-1:0]      pwdata;
  logic                   pwrite;
  logic                   psel;
  logic                   penable;
  logic [DATA_W-1:0]      prdata;
  logic [COUNTER_NUM-1:0] extern_din;
  wire  [COUNTER_NUM-1:0] extern_dout;
  logic                   intr;

  // four words per step: op, address, data, expected
  logic [31:0] steps [0:4*MAX_STEPS-1];
  string       test_names [0:15];
  int          n_steps;
  int          test_errs;
  int          tests_pass;
  int          tests_fail;
  int          cur;
  logic [31:0] saved;

  // expected waveform per channel, built from the APB writes on the bus
  logic [COUNTER_NUM-1:0]   wave_exp  = '0;
  logic [2*COUNTER_NUM-1:0] wave_pair = '0;
  logic                     run_ref    [COUNTER_NUM];
  logic [DATA_W-1:0]        target_ref [COUNTER_NUM];
  logic [DATA_W-1:0]        count_ref  [COUNTER_NUM];

  counter_top #(
    .COUNTER_NUM (COUNTER_NUM)
  ) dut_i (
    .i_pclk        (pclk),
    .i_prst_n      (prst_n),
    .i_paddr       (paddr),
    .i_pwdata      (pwdata),
    .i_pwrite      (pwrite),
    .i_psel        (psel),
    .i_penable     (penable),
    .o_prdata      (prdata),
    .i_extern_din  (extern_din),
    .o_extern_dout (extern_dout),
    .o_int         (intr)
  );

  initial begin
    pclk = 1'b0;
    forever #5 pclk = ~pclk;
  end

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge pclk);
    #1;
  endtask

  task automatic compare_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("mismatch %s expected %08h actual %08h", what, exp, act);
      test_errs++;
    end
  endtask

  // setup then one access cycle, write lands on the closing edge
  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [DATA_W-1:0] data);
    next_cycle();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // prdata registered at end of setup, sampled inside access
  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [DATA_W-1:0] data);
    next_cycle();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    next_cycle();
    penable = 1'b1;
    data    = prdata;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic report_test(input int id);
    if (test_errs == 0) begin
      $display("test %0d %s: ok", id, test_names[id]);
      tests_pass++;
    end else begin
      $display("test %0d %s: failed with %0d errors", id, test_names[id], test_errs);
      tests_fail++;
    end
    test_errs = 0;
  endtask

  // same edges as the DUT, a write edge still uses the old settings
  // clear wins, a match wraps to zero and toggles, else count while enabled
  always @(posedge pclk or negedge prst_n) begin : wave_model
    logic              wr;
    logic [APB_AW-1:0] rel;
    logic [APB_AW-1:0] off;
    if (!prst_n) begin
      for (int n = 0; n < COUNTER_NUM; n++) begin
        run_ref[n]    = 1'b0;
        target_ref[n] = '0;
        count_ref[n]  = '0;
      end
      wave_exp = '0;
    end else begin
      wr  = psel && penable && pwrite && (paddr >= CHAN_BASE);
      rel = paddr - CHAN_BASE;
      off = rel % CHAN_STRIDE;
      for (int n = 0; n < COUNTER_NUM; n++) begin
        if (wr && rel / CHAN_STRIDE == n && off == REG_CH_CMD && pwdata[0]) begin
          count_ref[n] = '0;
        end else if (run_ref[n] && count_ref[n] == target_ref[n]) begin
          count_ref[n] = '0;
          wave_exp[n]  = ~wave_exp[n];
        end else if (run_ref[n]) begin
          count_ref[n] = count_ref[n] + 1'b1;
        end
        if (wr && rel / CHAN_STRIDE == n && off == REG_CH_CTRL) begin
          run_ref[n] = pwdata[0];
        end
        if (wr && rel / CHAN_STRIDE == n && off == REG_CH_TARGET) begin
          target_ref[n] = pwdata;
        end
      end
    end
  end

  // waveform outputs checked whenever either side changes
  always @(negedge pclk) begin
    if ({extern_dout, wave_exp} !== wave_pair) begin
      compare_word($sformatf("%s o_extern_dout", test_names[cur]),
                   32'(wave_exp), 32'(extern_dout));
      wave_pair = {extern_dout, wave_exp};
    end
  end

  // limit scales with the amount of test data
  initial begin
    wait (n_steps > 0);
    repeat (200 * n_steps + 1000) @(posedge pclk);
    $display("watchdog expired before the test data was done");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
    logic [31:0] rd;
    string       what;

    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    extern_din = '0;
    prst_n     = 1'b0;
    for (int i = 0; i < 16; i++) begin
      test_names[i] = "unnamed";
    end
    test_names[1] = "readback";
    test_names[2] = "clear_hold";
    test_names[3] = "capture";
    test_names[4] = "compare_wave";
    test_names[5] = "intr_mask";
    for (int i = 0; i < 4 * MAX_STEPS; i++) begin
      steps[i] = '0;
    end
    $readmemh("tests/counter_testdata.txt", steps);
    // op 0 marks the end of the data
    while (n_steps < MAX_STEPS && steps[4*n_steps] != 0) begin
      n_steps++;
    end
    repeat (2) @(posedge pclk);
    #1;
    prst_n = 1'b1;
    cur = 0;
    for (int s = 0; s < n_steps; s++) begin
      op   = steps[4*s];
      addr = steps[4*s+1];
      data = steps[4*s+2];
      expv = steps[4*s+3];
      // high nibble of op is the test number
      if (op[7:4] != cur) begin
        if (cur != 0) begin
          report_test(cur);
        end
        cur = op[7:4];
      end
      what = $sformatf("%s step %0d", test_names[cur], s);
      case (op[3:0])
        4'h1: apb_write(addr[APB_AW-1:0], data);
        4'h2: begin
          // data column masks the bits under test
          apb_read(addr[APB_AW-1:0], rd);
          compare_word(what, expv, rd & data);
        end
        4'h3: repeat (data) next_cycle();
        4'h4: extern_din[addr[1:0]] = data[0];
        4'h5: begin
          // data column is the number of cycles allowed
          for (int k = 0; k < data && intr !== expv[0]; k++) begin
            next_cycle();
          end
          compare_word(what, expv, {31'b0, intr});
        end
        4'h6: begin
          apb_read(addr[APB_AW-1:0], saved);
          if (saved == 0) begin
            $display("%s: value read from %03h is zero", what, addr);
            test_errs++;
          end
        end
        4'h7: begin
          apb_read(addr[APB_AW-1:0], rd);
          compare_word(what, saved, rd);
        end
        default: begin
          $display("%s: unknown operation code %02h", what, op);
          test_errs++;
        end
      endcase
    end
    if (cur != 0) begin
      report_test(cur);
    end
    $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
    if (n_steps > 0 && tests_fail == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
